// File: verilog.f
+incdir+include
logic/trace_monitor_pkg.sv
logic/trace_ctrl_regs.sv
logic/trace_gate.sv
logic/trace_packer.sv
logic/trace_stream_out.sv
logic/trace_monitor.sv
test/trace_monitor_asserts.sv
test/trace_monitor_tb.sv

// File: run.sh
#!/bin/sh
# builds the trace monitor testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module trace_monitor_tb \
    -o trace_monitor_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/trace_monitor_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^=== PASS ===$'; then
    exit 0
fi
exit 1

// File: test/trace_monitor_tests.txt
# all numbers hex: T name | W addr data | R addr expected | I pc instr events
# D cycles events | S stall 1/0 | Q random_ready 1/0
T reg_reset
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
R 4 ffffffff
R 5 00000000
T reg_rw
W 1 00001000
R 1 00001000
W 4 00002000
R 4 00002000
W 4 ffffffff
W 1 00000000
W 5 00000000
R 5 00000000
T capture_off
I 00000100 00000013 0
D 3 0
T new_instr
W 0 00000001
I 00000104 00000093 1
I 00000104 00000093 1
D 2 0
I 00000108 00100113 3
I 0000010c 10500073 0
D 4 0
T triggers
W 1 00000200
W 2 0000020c
W 0 00000007
I 000001fc 00000013 0
I 00000200 00000013 0
I 00000204 00000013 2
I 00000208 00000013 0
I 0000020c 00000013 0
I 00000210 00000013 0
I 00000200 00000013 4
D 4 0
T range
W 3 00000300
W 4 00000308
W 0 00000019
I 000002fc 00000013 0
I 00000300 00000013 1
I 00000308 00000013 0
I 0000030c 00000013 0
D 4 0
T counts
W 0 00000001
Q 1
D 12c 1
I 00000400 00000013 f
D 6 5
I 00000404 00000113 0
D 6 a
I 00000408 10500073 0
D 6 0
Q 0
D 4 0
T backpressure
S 1
I 00000500 00000013 0
I 00000504 00000013 0
I 00000508 00000013 0
I 0000050c 00000013 0
D 5 0
S 0
D 4 0
R 5 00000002
W 5 00000000
R 5 00000000

// File: test/trace_monitor_tb.sv
// trace monitor testbench
// runs the command file, predicts every trace packet and checks the stream and registers
`timescale 1ns/10ps
`include "trace_monitor_defs.svh"

module trace_monitor_tb;
    import trace_monitor_pkg::*;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      pc_valid;
    pc_t                       pc;
    instr_t                    instr;
    logic [`TM_NUM_EVENTS-1:0] events;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    reg_addr_t                 wb_adr;
    reg_data_t                 wb_dat_w;
    reg_data_t                 wb_dat_r;
    logic                      wb_ack;
    logic                      m_axis_tvalid;
    logic                      m_axis_tready;
    trace_pkt_t                m_axis_tdata;
    logic                      m_axis_tlast;

    // reference model state, updated once per sample edge
    logic [31:0]   cfg_ctrl;
    pc_t           cfg_start;
    pc_t           cfg_end;
    pc_t           cfg_low;
    pc_t           cfg_high;
    pc_t           m_prev_pc;
    logic          m_active;
    logic          m_ended;
    ts_delta_t     m_ts;
    event_counts_t m_ev;
    trace_pkt_t    exp_q[$];

    string       test_name = "none";
    logic        stall_on;
    logic        rand_on;
    logic [31:0] lfsr = 32'hf81b_f5ab;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          err_cnt = 0;
    int          fd;
    string       cmd;
    string       tname;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    logic [31:0] arg_c;
    bit          got;
    reg_data_t   rdat;
    int          n_instr;
    int          n_idle;
    int          n_other;

    trace_monitor i_trace_monitor (.*);

    always #2 clk = ~clk;

    task automatic run_fail(input string why);
        err_cnt++;
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopping after the first error");
    endtask

    task automatic check_pkt(input trace_pkt_t exp, input trace_pkt_t act);
        if (exp !== act) begin
            run_fail($sformatf("CHECK FAILED %s packet: expected %h actual %h",
                               test_name, exp, act));
        end
    endtask

    task automatic check_last(input logic exp, input logic act);
        if (exp !== act) begin
            run_fail($sformatf("CHECK FAILED %s tlast: expected %b actual %b",
                               test_name, exp, act));
        end
    endtask

    task automatic check_reg(input reg_data_t exp, input reg_data_t act);
        if (exp !== act) begin
            run_fail($sformatf("CHECK FAILED %s register: expected %h actual %h",
                               test_name, exp, act));
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit, ready is low only when both bits are zero
    task automatic pick_ready(output logic rdy);
        logic b0;
        logic b1;
        b0 = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b1 = lfsr[0];
        lfsr = lfsr_next(lfsr);
        rdy = b0 | b1;
    endtask

    // applies the gate and packer rules to the inputs about to be sampled
    task automatic model_sample();
        logic       new_i;
        logic       start_hit;
        logic       end_hit;
        logic       tracing;
        logic       in_range;
        trace_pkt_t p;
        if (m_ts != 16'hffff) m_ts = m_ts + 16'd1;
        for (int i = 0; i < `TM_NUM_EVENTS; i++) begin
            if (events[i] && m_ev[i] != 8'hff) m_ev[i] = m_ev[i] + 8'd1;
        end
        new_i = pc_valid && (pc != m_prev_pc);
        if (pc_valid) m_prev_pc = pc;
        start_hit = cfg_ctrl[`TM_CTRL_START_EN] && (pc == cfg_start);
        end_hit = cfg_ctrl[`TM_CTRL_END_EN] && (pc == cfg_end);
        if (start_hit) tracing = 1'b1;
        else if (end_hit) tracing = 1'b0;
        else if (cfg_ctrl[`TM_CTRL_START_EN]) tracing = m_active;
        else tracing = !m_ended;
        if (new_i && start_hit) begin
            m_active = 1'b1;
            m_ended = 1'b0;
        end else if (new_i && end_hit) begin
            m_active = 1'b0;
            m_ended = 1'b1;
        end
        in_range = (!cfg_ctrl[`TM_CTRL_LOW_EN] || pc >= cfg_low)
                && (!cfg_ctrl[`TM_CTRL_HIGH_EN] || pc <= cfg_high);
        if (cfg_ctrl[`TM_CTRL_CAPTURE_EN] && new_i && tracing && in_range) begin
            p.instr = instr;
            p.pc = pc;
            p.ts_delta = m_ts;
            p.event_counts = m_ev;
            m_ts = '0;
            m_ev = '0;
            // nothing leaves the buffer while stalled, so the queue length is its fill
            if (!stall_on || exp_q.size() < `TM_BUF_DEPTH) exp_q.push_back(p);
        end
    endtask

    task automatic next_cycle();
        logic rdy;
        model_sample();
        @(posedge clk);
        #0.5;
        rdy = 1'b1;
        if (stall_on) rdy = 1'b0;
        else if (rand_on) pick_ready(rdy);
        m_axis_tready = rdy;
    endtask

    task automatic wb_access(input logic we, input reg_addr_t adr, input reg_data_t wdat,
                             output reg_data_t data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdat;
        do next_cycle(); while (!wb_ack);
        data = wb_dat_r;
        if (we) begin
            case (adr)
                `TM_REG_CTRL:  cfg_ctrl = {27'd0, wdat[4:0]};
                `TM_REG_START: cfg_start = wdat;
                `TM_REG_END:   cfg_end = wdat;
                `TM_REG_LOW:   cfg_low = wdat;
                `TM_REG_HIGH:  cfg_high = wdat;
                default:       ;
            endcase
        end
        next_cycle();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    // skips blank and # lines, a T line carries a name instead of numbers
    task automatic read_cmd(input int f, output string c, output string nm,
                            output logic [31:0] a, output logic [31:0] b,
                            output logic [31:0] d, output bit ok);
        string line;
        int    n;
        ok = 0;
        a = '0;
        b = '0;
        d = '0;
        while (!ok && !$feof(f)) begin
            n = $fgets(line, f);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s", c);
                if (c == "T") n = $sscanf(line, "%s %s", c, nm);
                else n = $sscanf(line, "%s %h %h %h", c, a, b, d);
                ok = 1;
            end
        end
    endtask

    // a transfer happens at the rising edge after a low phase with valid and ready
    always @(negedge clk) begin
        trace_pkt_t exp_pkt;
        if (rst_n && m_axis_tvalid && m_axis_tready) begin
            if (exp_q.size() == 0) begin
                run_fail($sformatf("unexpected packet in test %s: %h", test_name, m_axis_tdata));
            end else begin
                exp_pkt = exp_q.pop_front();
                check_pkt(exp_pkt, m_axis_tdata);
                check_last(exp_pkt.instr == `TM_WFI_INSTR, m_axis_tlast);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            run_fail($sformatf("timeout: the run took more than %0d cycles", cycle_limit));
        end
    end

    initial begin
        rst_n = 1'b0;
        pc_valid = 1'b0;
        pc = '0;
        instr = '0;
        events = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        m_axis_tready = 1'b1;
        stall_on = 1'b0;
        rand_on = 1'b0;
        cfg_ctrl = '0;
        cfg_start = '0;
        cfg_end = '0;
        cfg_low = '0;
        cfg_high = '1;
        m_prev_pc = '0;
        m_active = 1'b0;
        m_ended = 1'b0;
        m_ts = '0;
        m_ev = '0;
        n_instr = 0;
        n_idle = 0;
        n_other = 0;

        // first pass sizes the timeout
        fd = $fopen("test/trace_monitor_tests.txt", "r");
        if (fd == 0) run_fail("cannot open the test command file");
        read_cmd(fd, cmd, tname, arg_a, arg_b, arg_c, got);
        while (got) begin
            if (cmd == "I") n_instr++;
            else if (cmd == "D") n_idle += int'(arg_a);
            else n_other++;
            read_cmd(fd, cmd, tname, arg_a, arg_b, arg_c, got);
        end
        $fclose(fd);
        cycle_limit = 4 * n_instr + n_idle + 8 * n_other + 200;

        repeat (2) @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        fd = $fopen("test/trace_monitor_tests.txt", "r");
        read_cmd(fd, cmd, tname, arg_a, arg_b, arg_c, got);
        while (got) begin
            case (cmd)
                "T": test_name = tname;
                "W": wb_access(1'b1, arg_a[2:0], arg_b, rdat);
                "R": begin
                    wb_access(1'b0, arg_a[2:0], '0, rdat);
                    check_reg(arg_b, rdat);
                end
                "I": begin
                    pc_valid = 1'b1;
                    pc = arg_a;
                    instr = arg_b;
                    events = arg_c[`TM_NUM_EVENTS-1:0];
                    next_cycle();
                    pc_valid = 1'b0;
                    // the pc keeps moving while pc_valid is low and must not count as new
                    pc = ~arg_a;
                    events = '0;
                end
                "D": begin
                    events = arg_b[`TM_NUM_EVENTS-1:0];
                    repeat (int'(arg_a)) next_cycle();
                    events = '0;
                end
                "S": stall_on = arg_a[0];
                "Q": rand_on = arg_a[0];
                default: run_fail($sformatf("unknown command %s in the test file", cmd));
            endcase
            read_cmd(fd, cmd, tname, arg_a, arg_b, arg_c, got);
        end
        $fclose(fd);

        test_name = "drain";
        while (exp_q.size() != 0) next_cycle();
        repeat (4) next_cycle();

        if (err_cnt == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            run_fail("errors were recorded during the run");
        end
    end

endmodule

// File: test/trace_monitor_asserts.sv
// handshake checks for the trace monitor
// Wishbone ack behavior and AXI-Stream stability under back-pressure
`timescale 1ns/10ps

module trace_monitor_asserts (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          wb_cyc,
    input logic                          wb_stb,
    input logic                          wb_ack,
    input logic                          m_axis_tvalid,
    input logic                          m_axis_tready,
    input trace_monitor_pkg::trace_pkt_t m_axis_tdata,
    input logic                          m_axis_tlast
);

    stream_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_axis_tvalid && !m_axis_tready |=> $stable(m_axis_tdata) && $stable(m_axis_tlast))
        else $error("stream data or tlast changed while stalled");

    valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid)
        else $error("tvalid dropped without tready");

    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> wb_cyc && wb_stb)
        else $error("wb_ack high outside a bus cycle");

    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high two cycles in a row");

endmodule

bind trace_monitor trace_monitor_asserts i_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_ack        (wb_ack),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast)
);

// File: logic/trace_monitor.sv
// continuous trace monitor for a RISC-V core
// register bank, trace gate, packet builder and stream buffer in one chain
`timescale 1ns/10ps
`include "trace_monitor_defs.svh"

module trace_monitor (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           pc_valid,
    input  trace_monitor_pkg::pc_t         pc,
    input  trace_monitor_pkg::instr_t      instr,
    input  logic [`TM_NUM_EVENTS-1:0]      events,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  trace_monitor_pkg::reg_addr_t   wb_adr,
    input  trace_monitor_pkg::reg_data_t   wb_dat_w,
    output trace_monitor_pkg::reg_data_t   wb_dat_r,
    output logic                           wb_ack,
    output logic                           m_axis_tvalid,
    input  logic                           m_axis_tready,
    output trace_monitor_pkg::trace_pkt_t  m_axis_tdata,
    output logic                           m_axis_tlast
);
    localparam int PKT_W = `TM_INSTR_WIDTH + `TM_XLEN + `TM_TS_WIDTH
                         + `TM_NUM_EVENTS * `TM_EVENT_CNT_WIDTH;

    logic                       capture_en;
    logic                       start_en;
    logic                       end_en;
    logic                       low_en;
    logic                       high_en;
    logic [`TM_XLEN-1:0]        start_addr;
    logic [`TM_XLEN-1:0]        end_addr;
    logic [`TM_XLEN-1:0]        range_low;
    logic [`TM_XLEN-1:0]        range_high;
    logic                       capture;
    logic [`TM_XLEN-1:0]        cap_pc;
    logic [`TM_INSTR_WIDTH-1:0] cap_instr;
    logic [PKT_W-1:0]           pkt;
    logic                       pkt_valid;
    logic                       dropped;

    trace_ctrl_regs i_ctrl_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .dropped    (dropped),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .capture_en (capture_en),
        .start_en   (start_en),
        .end_en     (end_en),
        .low_en     (low_en),
        .high_en    (high_en),
        .start_addr (start_addr),
        .end_addr   (end_addr),
        .range_low  (range_low),
        .range_high (range_high)
    );

    trace_gate i_gate (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc_valid   (pc_valid),
        .pc         (pc),
        .instr      (instr),
        .capture_en (capture_en),
        .start_en   (start_en),
        .end_en     (end_en),
        .low_en     (low_en),
        .high_en    (high_en),
        .start_addr (start_addr),
        .end_addr   (end_addr),
        .range_low  (range_low),
        .range_high (range_high),
        .capture    (capture),
        .cap_pc     (cap_pc),
        .cap_instr  (cap_instr)
    );

    trace_packer i_packer (
        .clk       (clk),
        .rst_n     (rst_n),
        .capture   (capture),
        .cap_pc    (cap_pc),
        .cap_instr (cap_instr),
        .events    (events),
        .pkt       (pkt),
        .pkt_valid (pkt_valid)
    );

    trace_stream_out #(
        .DEPTH (`TM_BUF_DEPTH)
    ) i_stream_out (
        .clk           (clk),
        .rst_n         (rst_n),
        .pkt_valid     (pkt_valid),
        .pkt           (pkt),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast),
        .dropped       (dropped)
    );

endmodule

// File: logic/trace_stream_out.sv
// trace packet buffer with an AXI-Stream master output
// packets that find the buffer full are discarded and reported by a dropped pulse
`timescale 1ns/10ps
`include "trace_monitor_defs.svh"

module trace_stream_out #(
    parameter int DEPTH = `TM_BUF_DEPTH
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           pkt_valid,
    input  trace_monitor_pkg::trace_pkt_t  pkt,
    input  logic                           m_axis_tready,
    output logic                           m_axis_tvalid,
    output trace_monitor_pkg::trace_pkt_t  m_axis_tdata,
    output logic                           m_axis_tlast,
    output logic                           dropped
);
    import trace_monitor_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    trace_pkt_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full = (count == CNT_W'(DEPTH));
    assign pop  = m_axis_tvalid && m_axis_tready;
    // a full buffer still takes a packet in the cycle it hands one out
    assign push = pkt_valid && (!full || pop);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            dropped <= 1'b0;
        end else begin
            dropped <= pkt_valid && !push;
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the head entry is only rewritten by the transfer that retires it
    assign m_axis_tvalid = (count != '0);
    assign m_axis_tdata  = mem[rd_ptr];
    assign m_axis_tlast  = m_axis_tvalid && (m_axis_tdata.instr == `TM_WFI_INSTR);

endmodule

// File: logic/trace_packer.sv
// trace packer
// counts sample cycles and event occurrences between captures and builds
// one trace packet per capture strobe
`timescale 1ns/10ps
`include "trace_monitor_defs.svh"

module trace_packer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           capture,
    input  trace_monitor_pkg::pc_t         cap_pc,
    input  trace_monitor_pkg::instr_t      cap_instr,
    input  logic [`TM_NUM_EVENTS-1:0]      events,
    output trace_monitor_pkg::trace_pkt_t  pkt,
    output logic                           pkt_valid
);
    import trace_monitor_pkg::*;

    logic [`TM_NUM_EVENTS-1:0] events_q;
    logic                      sampled;
    ts_delta_t                 ts_cnt;
    ts_delta_t                 ts_next;
    event_counts_t             ev_cnt;
    event_counts_t             ev_next;

    // events line up with the sample held in the gate
    // sampled stays low for the cycle after reset so the reset edge is not counted
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            events_q <= '0;
            sampled  <= 1'b0;
        end else begin
            events_q <= events;
            sampled  <= 1'b1;
        end
    end

    // counts including the sample currently held, all saturating
    always_comb begin
        ts_next = (ts_cnt == '1) ? ts_cnt : ts_cnt + ts_delta_t'(sampled);
        for (int i = 0; i < `TM_NUM_EVENTS; i++) begin
            if (ev_cnt[i] == '1) begin
                ev_next[i] = ev_cnt[i];
            end else begin
                ev_next[i] = ev_cnt[i] + {{(`TM_EVENT_CNT_WIDTH-1){1'b0}}, events_q[i]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ts_cnt    <= '0;
            ev_cnt    <= '0;
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= capture;
            if (capture) begin
                ts_cnt <= '0;
                ev_cnt <= '0;
            end else begin
                ts_cnt <= ts_next;
                ev_cnt <= ev_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            pkt.instr        <= cap_instr;
            pkt.pc           <= cap_pc;
            pkt.ts_delta     <= ts_next;
            pkt.event_counts <= ev_next;
        end
    end

endmodule

// File: logic/trace_gate.sv
// trace gate
// samples the retiring pc and instr, finds new instructions and applies
// the start/end triggers and the address range to raise the capture strobe
`timescale 1ns/10ps

module trace_gate (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pc_valid,
    input  trace_monitor_pkg::pc_t     pc,
    input  trace_monitor_pkg::instr_t  instr,
    input  logic                       capture_en,
    input  logic                       start_en,
    input  logic                       end_en,
    input  logic                       low_en,
    input  logic                       high_en,
    input  trace_monitor_pkg::pc_t     start_addr,
    input  trace_monitor_pkg::pc_t     end_addr,
    input  trace_monitor_pkg::pc_t     range_low,
    input  trace_monitor_pkg::pc_t     range_high,
    output logic                       capture,
    output trace_monitor_pkg::pc_t     cap_pc,
    output trace_monitor_pkg::instr_t  cap_instr
);
    import trace_monitor_pkg::*;

    pc_t    pc_q;
    instr_t instr_q;
    pc_t    prev_pc;
    logic   valid_q;
    logic   trig_on;
    logic   trig_off;
    logic   new_instr;
    logic   start_hit;
    logic   end_hit;
    logic   tracing;
    logic   in_range;

    always_ff @(posedge clk) begin
        pc_q    <= pc;
        instr_q <= instr;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            prev_pc  <= '0;
            trig_on  <= 1'b0;
            trig_off <= 1'b0;
        end else begin
            valid_q <= pc_valid;
            if (valid_q) begin
                prev_pc <= pc_q;
            end
            // a start match takes priority when both addresses are equal
            if (new_instr && start_hit) begin
                trig_on  <= 1'b1;
                trig_off <= 1'b0;
            end else if (new_instr && end_hit) begin
                trig_on  <= 1'b0;
                trig_off <= 1'b1;
            end
        end
    end

    assign new_instr = valid_q && (pc_q != prev_pc);
    assign start_hit = start_en && (pc_q == start_addr);
    assign end_hit   = end_en && (pc_q == end_addr);

    // the matching instruction itself is traced on start and skipped on end
    always_comb begin
        if (start_hit) begin
            tracing = 1'b1;
        end else if (end_hit) begin
            tracing = 1'b0;
        end else if (start_en) begin
            tracing = trig_on;
        end else begin
            tracing = !trig_off;
        end
    end

    assign in_range = (!low_en || pc_q >= range_low) && (!high_en || pc_q <= range_high);

    assign capture   = capture_en && new_instr && tracing && in_range;
    assign cap_pc    = pc_q;
    assign cap_instr = instr_q;

endmodule

// File: logic/trace_ctrl_regs.sv
// trace monitor register bank
// Wishbone classic slave with control, trigger, range and dropped-count registers
`timescale 1ns/10ps
`include "trace_monitor_defs.svh"

module trace_ctrl_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  trace_monitor_pkg::reg_addr_t  wb_adr,
    input  trace_monitor_pkg::reg_data_t  wb_dat_w,
    input  logic                          dropped,
    output trace_monitor_pkg::reg_data_t  wb_dat_r,
    output logic                          wb_ack,
    output logic                          capture_en,
    output logic                          start_en,
    output logic                          end_en,
    output logic                          low_en,
    output logic                          high_en,
    output trace_monitor_pkg::pc_t        start_addr,
    output trace_monitor_pkg::pc_t        end_addr,
    output trace_monitor_pkg::pc_t        range_low,
    output trace_monitor_pkg::pc_t        range_high
);
    import trace_monitor_pkg::*;

    logic [`TM_CTRL_HIGH_EN:0] ctrl;
    reg_data_t                 dropped_cnt;
    logic                      wb_req;
    logic                      wb_wr;

    // a request not yet acknowledged, so ack can never be high two cycles running
    assign wb_req = wb_cyc && wb_stb && !wb_ack;
    assign wb_wr  = wb_req && wb_we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack      <= 1'b0;
            ctrl        <= '0;
            start_addr  <= '0;
            end_addr    <= '0;
            range_low   <= '0;
            range_high  <= '1;
            dropped_cnt <= '0;
        end else begin
            wb_ack <= wb_req;
            if (wb_wr) begin
                case (wb_adr)
                    `TM_REG_CTRL:  ctrl <= wb_dat_w[`TM_CTRL_HIGH_EN:0];
                    `TM_REG_START: start_addr <= wb_dat_w;
                    `TM_REG_END:   end_addr <= wb_dat_w;
                    `TM_REG_LOW:   range_low <= wb_dat_w;
                    `TM_REG_HIGH:  range_high <= wb_dat_w;
                    default:       ;
                endcase
            end
            // clearing by a write wins over a drop in the same cycle
            if (wb_wr && wb_adr == `TM_REG_DROPPED) begin
                dropped_cnt <= '0;
            end else if (dropped && dropped_cnt != '1) begin
                dropped_cnt <= dropped_cnt + 1'b1;
            end
        end
    end

    // read data is captured on the edge that raises ack
    always_ff @(posedge clk) begin
        if (wb_req) begin
            case (wb_adr)
                `TM_REG_CTRL:    wb_dat_r <= reg_data_t'(ctrl);
                `TM_REG_START:   wb_dat_r <= start_addr;
                `TM_REG_END:     wb_dat_r <= end_addr;
                `TM_REG_LOW:     wb_dat_r <= range_low;
                `TM_REG_HIGH:    wb_dat_r <= range_high;
                `TM_REG_DROPPED: wb_dat_r <= dropped_cnt;
                default:         wb_dat_r <= '0;
            endcase
        end
    end

    assign capture_en = ctrl[`TM_CTRL_CAPTURE_EN];
    assign start_en   = ctrl[`TM_CTRL_START_EN];
    assign end_en     = ctrl[`TM_CTRL_END_EN];
    assign low_en     = ctrl[`TM_CTRL_LOW_EN];
    assign high_en    = ctrl[`TM_CTRL_HIGH_EN];

endmodule

// File: logic/trace_monitor_pkg.sv
// trace monitor data types
// the trace packet is the AXI-Stream payload, instr in the top bits
`include "trace_monitor_defs.svh"

package trace_monitor_pkg;

    typedef logic [`TM_XLEN-1:0] pc_t;

    typedef logic [`TM_INSTR_WIDTH-1:0] instr_t;

    typedef logic [`TM_XLEN-1:0] reg_data_t;

    typedef logic [2:0] reg_addr_t;

    typedef logic [`TM_TS_WIDTH-1:0] ts_delta_t;

    // one saturating count per performance event line, event 0 in the low byte
    typedef logic [`TM_NUM_EVENTS-1:0][`TM_EVENT_CNT_WIDTH-1:0] event_counts_t;

    typedef struct packed {
        instr_t        instr;
        pc_t           pc;
        ts_delta_t     ts_delta;
        event_counts_t event_counts;
    } trace_pkt_t;

endpackage

// File: include/trace_monitor_defs.svh
// trace monitor widths, register map and encodings
// shared by the package and by every block that needs a constant
`ifndef TRACE_MONITOR_DEFS_SVH
`define TRACE_MONITOR_DEFS_SVH

`define TM_XLEN             32
`define TM_INSTR_WIDTH      32
`define TM_TS_WIDTH         16
`define TM_NUM_EVENTS       4
`define TM_EVENT_CNT_WIDTH  8
`define TM_WFI_INSTR        32'h10500073
`define TM_BUF_DEPTH        2

// Wishbone word addresses
`define TM_REG_CTRL         3'd0
`define TM_REG_START        3'd1
`define TM_REG_END          3'd2
`define TM_REG_LOW          3'd3
`define TM_REG_HIGH         3'd4
`define TM_REG_DROPPED      3'd5

// bit positions inside the control register
`define TM_CTRL_CAPTURE_EN  0
`define TM_CTRL_START_EN    1
`define TM_CTRL_END_EN      2
`define TM_CTRL_LOW_EN      3
`define TM_CTRL_HIGH_EN     4

`endif
